//--- files.f
+incdir+logic
logic/dac_regs_pkg.sv
logic/dac_spi_pkg.sv
logic/dac_reg_if.sv
logic/avmm_reg_slave.sv
logic/dac_update_seq.sv
logic/dac_spi_shifter.sv
logic/dac_ctrl_top.sv
bench/bench_clock.sv
bench/dac_ctrl_chk.sv
bench/dac_ctrl_bench.sv

//--- Bender.yml
package:
  name: dac_ctrl

sources:
  - include_dirs:
      - logic
    files:
      - logic/dac_regs_pkg.sv
      - logic/dac_spi_pkg.sv
      - logic/dac_reg_if.sv
      - logic/avmm_reg_slave.sv
      - logic/dac_update_seq.sv
      - logic/dac_spi_shifter.sv
      - logic/dac_ctrl_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/bench_clock.sv
      - bench/dac_ctrl_chk.sv
      - bench/dac_ctrl_bench.sv

//--- bench/dac_ctrl_bench.sv
//////////////////////////////////////////////////////////////////////
// DAC controller testbench
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "dac_ctrl_config.svh"

module dac_ctrl_bench;
    import dac_regs_pkg::*;
    import dac_spi_pkg::*;

    localparam int BUS_TIMEOUT  = 8;
    localparam int IDLE_TIMEOUT = 300;   // polls, each one or two cycles

    logic                         clk_ifc;
    logic                         set_default_on_reset;
    bus_addr_t                    avmm_address;
    logic                         avmm_read;
    logic                         avmm_write;
    reg_word_t                    avmm_writedata;
    logic [`DAC_DATA_WIDTH/8-1:0] avmm_byteenable;
    logic                         avmm_waitrequest;
    reg_word_t                    avmm_readdata;
    logic                         avmm_readdatavalid;
    logic                         avmm_writeresponsevalid;
    avmm_resp_e                   avmm_response;
    logic                         en_avmm_ctrl;
    dac_code_t                    dac_data_in;
    logic                         dac_data_in_valid_stb;
    logic                         dac_data_in_updated_stb;
    logic                         initdone;
    logic                         sclk;
    logic                         sync_n;
    logic                         sdin;

    int          errors;
    int          checks;
    int          strobe_cnt;
    int          rx_bits;
    logic [31:0] rng_state;
    dac_frame_t  rx_shift;
    dac_frame_t  model_dac;    // expected DAC_REG contents
    dac_frame_t  frames[$];    // decoded from the pins

    bench_clock bench_clock_inst (.clk(clk_ifc));

    dac_ctrl_top dac_ctrl_top_inst (.*);

    bind dac_ctrl_top dac_ctrl_chk dac_ctrl_chk_inst (
        .clk_ifc                 (clk_ifc),
        .set_default_on_reset    (set_default_on_reset),
        .spi_req                 (spi_req),
        .spi_ack                 (spi_ack),
        .spi_frame               (spi_frame),
        .sclk                    (sclk),
        .sync_n                  (sync_n),
        .dac_data_in_updated_stb (dac_data_in_updated_stb)
    );

    //////////////////////////////////////////////////////////////////////
    // pin decoder and strobe counter
    //////////////////////////////////////////////////////////////////////

    always @(negedge sclk) begin
        if (sync_n === 1'b0) begin
            rx_shift = {rx_shift[`DAC_FRAME_BITS-2:0], sdin};   // MSB first
            rx_bits++;
            if (rx_bits == `DAC_FRAME_BITS) begin
                frames.push_back(rx_shift);
                rx_bits = 0;
            end
        end
    end

    always @(posedge clk_ifc) begin
        if (dac_data_in_updated_stb === 1'b1) begin
            strobe_cnt++;
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic bus_addr_t byte_addr(input word_addr_t idx);
        return bus_addr_t'({idx, 2'b00});
    endfunction

    task automatic tick();
        @(posedge clk_ifc);
        #1;   // drive point
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_cond(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            $display("error: %s", what);
            errors++;
        end
    endtask

    task automatic check_last_frame(input dac_frame_t exp);
        check_cond(frames.size() > 0, "no SPI frame was decoded from the pins");
        if (frames.size() > 0) begin
            check_val("sdin frame", frames[$], exp);
        end
    endtask

    task automatic bus_read(input bus_addr_t addr, output reg_word_t data,
                            output avmm_resp_e resp);
        int n;
        avmm_address = addr;
        avmm_read    = 1'b1;
        tick();
        avmm_read = 1'b0;
        n = 1;
        while (avmm_readdatavalid !== 1'b1 && n < BUS_TIMEOUT) begin
            tick();
            n++;
        end
        check_cond(n == 1, "read response did not come one cycle after the read");
        data = avmm_readdata;
        resp = avmm_response;
    endtask

    task automatic bus_write(input bus_addr_t addr, input reg_word_t data,
                             input logic [3:0] be, output avmm_resp_e resp);
        int n;
        avmm_address    = addr;
        avmm_writedata  = data;
        avmm_byteenable = be;
        avmm_write      = 1'b1;
        tick();
        avmm_write = 1'b0;
        n = 1;
        while (avmm_writeresponsevalid !== 1'b1 && n < BUS_TIMEOUT) begin
            tick();
            n++;
        end
        check_cond(n == 1, "write response did not come one cycle after the write");
        resp = avmm_response;
    endtask

    // polls DEVICE_STATE until busy clears
    task automatic wait_idle();
        reg_word_t  st;
        avmm_resp_e rsp;
        int         n;
        tick();
        tick();   // let a fresh update reach the sequencer
        n = 0;
        bus_read(byte_addr(DEVICE_STATE), st, rsp);
        while (st[1] !== 1'b0 && n < IDLE_TIMEOUT) begin
            bus_read(byte_addr(DEVICE_STATE), st, rsp);
            n++;
        end
        check_cond(st[1] === 1'b0, "timeout waiting for the sequencer to go idle");
    endtask

    task automatic report(input string name, input int err0);
        $display("test %s: %s (%0d errors)", name,
                 (errors == err0) ? "ok" : "failed", errors - err0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    initial begin
        reg_word_t  rd;
        reg_word_t  r;
        avmm_resp_e rsp;
        bus_addr_t  ad;
        dac_code_t  code;
        int         err0;
        int         base;
        errors                = 0;
        checks                = 0;
        strobe_cnt            = 0;
        rx_bits               = 0;
        rx_shift              = '0;
        rng_state             = 32'd58;
        set_default_on_reset  = 1'b1;
        avmm_address          = '0;
        avmm_read             = 1'b0;
        avmm_write            = 1'b0;
        avmm_writedata        = '0;
        avmm_byteenable       = '0;
        en_avmm_ctrl          = 1'b1;
        dac_data_in           = '0;
        dac_data_in_valid_stb = 1'b0;
        model_dac             = `DAC_DEFAULT;

        // reset sends the default frame
        err0 = errors;
        for (int i = 0; i < 3; i++) begin
            tick();
            check_val("avmm_waitrequest", avmm_waitrequest, 1);
        end
        set_default_on_reset = 1'b0;
        wait_idle();
        check_cond(frames.size() == 1, "reset did not send exactly one frame");
        check_last_frame(`DAC_DEFAULT);
        check_val("initdone", initdone, 1);
        bus_read(byte_addr(DAC_REG), rd, rsp);
        check_val("avmm_readdata", rd, `DAC_DEFAULT);
        report("reset_default", err0);

        // fixed registers and undefined addresses
        err0 = errors;
        bus_read(byte_addr(VERSION_ID), rd, rsp);
        check_val("avmm_readdata", rd, {`DAC_MODULE_VERSION, `DAC_MODULE_ID});
        check_val("avmm_response", rsp, OKAY);
        bus_read(byte_addr(NUM_REGS), rd, rsp);
        check_val("avmm_readdata", rd, 5);
        bus_read(byte_addr(DEVICE_STATE), rd, rsp);
        check_val("avmm_readdata", rd, 1);   // init done, not busy
        bus_read(byte_addr(EN_AVMM_CTRL), rd, rsp);
        check_val("avmm_readdata", rd, 1);
        en_avmm_ctrl = 1'b0;
        bus_read(byte_addr(EN_AVMM_CTRL), rd, rsp);
        check_val("avmm_readdata", rd, 0);
        en_avmm_ctrl = 1'b1;
        for (int i = 0; i < 4; i++) begin
            r  = next_random();
            ad = byte_addr(word_addr_t'(TOTAL_REGS + r % 59));
            bus_read(ad, rd, rsp);
            check_val("avmm_readdata", rd, 0);
            check_val("avmm_response", rsp, SLAVE_ERROR);
            bus_write(ad, r, 4'hf, rsp);
            check_val("avmm_response", rsp, SLAVE_ERROR);
        end
        report("register_map", err0);

        // byte-enable masked writes
        err0 = errors;
        for (int i = 0; i < 6; i++) begin
            r = next_random();
            bus_write(byte_addr(DAC_REG), r, r[31:28], rsp);
            check_val("avmm_response", rsp, OKAY);
            model_dac = {r[29] ? r[15:8] : model_dac[15:8], r[28] ? r[7:0] : model_dac[7:0]};
            bus_read(byte_addr(DAC_REG), rd, rsp);
            check_val("avmm_readdata", rd, {16'h0, model_dac});
        end
        wait_idle();
        check_last_frame(model_dac);
        report("masked_writes", err0);

        // stream codes with the bus locked out
        err0 = errors;
        en_avmm_ctrl = 1'b0;
        base = strobe_cnt;
        for (int i = 0; i < 5; i++) begin
            r                     = next_random();
            code                  = r[7:0];
            dac_data_in           = code;
            dac_data_in_valid_stb = 1'b1;
            tick();
            dac_data_in_valid_stb = 1'b0;
            model_dac[`DAC_CODE_LSB +: `DAC_CODE_BITS] = code;
            wait_idle();
            check_last_frame(model_dac);
        end
        check_val("dac_data_in_updated_stb count", strobe_cnt - base, 5);
        bus_write(byte_addr(DAC_REG), next_random(), 4'hf, rsp);
        bus_read(byte_addr(DAC_REG), rd, rsp);
        check_val("avmm_readdata", rd, {16'h0, model_dac});
        en_avmm_ctrl = 1'b1;
        report("stream_mode", err0);

        // back-to-back writes fold into one follow-up frame
        err0 = errors;
        base = frames.size();
        for (int i = 0; i < 5; i++) begin
            r               = next_random();
            avmm_address    = byte_addr(DAC_REG);
            avmm_writedata  = r;
            avmm_byteenable = 4'hf;
            avmm_write      = 1'b1;
            model_dac       = r[15:0];
            tick();
        end
        avmm_write = 1'b0;
        wait_idle();
        check_cond(frames.size() - base <= 6, "more frames than writes plus one");
        // first write starts a frame, the other four land in that transfer
        check_cond(frames.size() - base == 2,
                   "writes during one transfer were not folded into one follow-up frame");
        check_last_frame(model_dac);
        report("coalescing", err0);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- bench/dac_ctrl_chk.sv
//////////////////////////////////////////////////////////////////////
// Handshake and pin checks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module dac_ctrl_chk (
    input var logic                    clk_ifc,
    input var logic                    set_default_on_reset,
    input var logic                    spi_req,
    input var logic                    spi_ack,
    input var dac_spi_pkg::dac_frame_t spi_frame,
    input var logic                    sclk,
    input var logic                    sync_n,
    input var logic                    dac_data_in_updated_stb
);

    // sequencer holds req until the shifter answers
    req_held: assert property (@(posedge clk_ifc) disable iff (set_default_on_reset)
        spi_req && !spi_ack |=> spi_req)
        else $error("spi_req dropped before spi_ack rose");

    frame_stable: assert property (@(posedge clk_ifc) disable iff (set_default_on_reset)
        spi_req |=> !spi_req || $stable(spi_frame))
        else $error("spi_frame changed while spi_req was high");

    // sclk idles high outside a frame
    sclk_idle: assert property (@(posedge clk_ifc) disable iff (set_default_on_reset)
        sync_n |-> sclk)
        else $error("sclk low while sync_n high");

    strobe_width: assert property (@(posedge clk_ifc) disable iff (set_default_on_reset)
        dac_data_in_updated_stb |=> !dac_data_in_updated_stb)
        else $error("dac_data_in_updated_stb longer than one cycle");

endmodule

//--- bench/bench_clock.sv
//////////////////////////////////////////////////////////////////////
// Bench clock
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module bench_clock (
    output var logic clk
);

    initial clk = 1'b0;

    always #50 clk = ~clk;   // 100 ns period

endmodule

//--- logic/dac_ctrl_top.sv
//////////////////////////////////////////////////////////////////////
// AD5601 DAC controller top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "dac_ctrl_config.svh"

module dac_ctrl_top (
    input  var logic                         clk_ifc,
    input  var logic                         set_default_on_reset,
    input  var dac_regs_pkg::bus_addr_t      avmm_address,
    input  var logic                         avmm_read,
    input  var logic                         avmm_write,
    input  var dac_regs_pkg::reg_word_t      avmm_writedata,
    input  var logic [`DAC_DATA_WIDTH/8-1:0] avmm_byteenable,
    output var logic                         avmm_waitrequest,
    output var dac_regs_pkg::reg_word_t      avmm_readdata,
    output var logic                         avmm_readdatavalid,
    output var logic                         avmm_writeresponsevalid,
    output var dac_regs_pkg::avmm_resp_e     avmm_response,
    input  var logic                         en_avmm_ctrl,
    input  var dac_spi_pkg::dac_code_t       dac_data_in,
    input  var logic                         dac_data_in_valid_stb,
    output var logic                         dac_data_in_updated_stb,
    output var logic                         initdone,
    output var logic                         sclk,
    output var logic                         sync_n,
    output var logic                         sdin
);

    logic                    spi_req;
    logic                    spi_ack;
    dac_spi_pkg::dac_frame_t spi_frame;

    dac_reg_if dac_if ();

    assign initdone = dac_if.init_done;

    avmm_reg_slave avmm_reg_slave_inst (
        .clk_ifc                 (clk_ifc),
        .set_default_on_reset    (set_default_on_reset),
        .avmm_address            (avmm_address),
        .avmm_read               (avmm_read),
        .avmm_write              (avmm_write),
        .avmm_writedata          (avmm_writedata),
        .avmm_byteenable         (avmm_byteenable),
        .avmm_waitrequest        (avmm_waitrequest),
        .avmm_readdata           (avmm_readdata),
        .avmm_readdatavalid      (avmm_readdatavalid),
        .avmm_writeresponsevalid (avmm_writeresponsevalid),
        .avmm_response           (avmm_response),
        .en_avmm_ctrl            (en_avmm_ctrl),
        .dac_data_in             (dac_data_in),
        .dac_data_in_valid_stb   (dac_data_in_valid_stb),
        .dac                     (dac_if.reg_side)
    );

    dac_update_seq dac_update_seq_inst (
        .clk_ifc                 (clk_ifc),
        .set_default_on_reset    (set_default_on_reset),
        .spi_ack                 (spi_ack),
        .spi_req                 (spi_req),
        .spi_frame               (spi_frame),
        .dac_data_in_updated_stb (dac_data_in_updated_stb),
        .dac                     (dac_if.seq_side)
    );

    dac_spi_shifter dac_spi_shifter_inst (
        .clk_ifc                 (clk_ifc),
        .set_default_on_reset    (set_default_on_reset),
        .spi_req                 (spi_req),
        .spi_frame               (spi_frame),
        .spi_ack                 (spi_ack),
        .sclk                    (sclk),
        .sync_n                  (sync_n),
        .sdin                    (sdin)
    );

endmodule

//--- logic/dac_spi_shifter.sv
//////////////////////////////////////////////////////////////////////
// AD5601 SPI serializer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "dac_ctrl_config.svh"

module dac_spi_shifter (
    input  var logic                    clk_ifc,
    input  var logic                    set_default_on_reset,
    input  var logic                    spi_req,
    input  var dac_spi_pkg::dac_frame_t spi_frame,
    output var logic                    spi_ack,
    output var logic                    sclk,
    output var logic                    sync_n,
    output var logic                    sdin
);
    import dac_spi_pkg::*;

    logic [$clog2(`DAC_SCLK_DIV+1)-1:0] div_cnt;
    logic [$clog2(`DAC_FRAME_BITS)-1:0] bit_cnt;
    logic                               active;
    logic                               done;      // sync_n just went back high
    logic                               tick;      // end of a half period
    logic                               start;
    dac_frame_t                         shreg;

    assign tick  = (div_cnt == `DAC_SCLK_DIV - 1);
    assign start = ~active & ~done & spi_req & ~spi_ack;
    assign sdin  = shreg[`DAC_FRAME_BITS-1];   // MSB first

    //////////////////////////////////////////////////////////////////////
    // sclk, sync_n and handshake
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            active  <= 1'b0;
            done    <= 1'b0;
            spi_ack <= 1'b0;
            sclk    <= 1'b1;
            sync_n  <= 1'b1;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (!active) begin
                div_cnt <= '0;
                bit_cnt <= '0;
                if (done) begin
                    spi_ack <= 1'b1;
                end else if (spi_ack && !spi_req) begin
                    spi_ack <= 1'b0;
                end else if (start) begin
                    active <= 1'b1;
                    sync_n <= 1'b0;    // sclk stays high for the first half
                end
            end else begin
                div_cnt <= tick ? '0 : div_cnt + 1'b1;
                if (tick) begin
                    if (sclk) begin
                        sclk <= 1'b0;  // DAC samples here
                    end else begin
                        sclk <= 1'b1;
                        if (bit_cnt == `DAC_FRAME_BITS - 1) begin
                            active <= 1'b0;
                            sync_n <= 1'b1;
                            done   <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
            end
        end
    end

    // shift on the rising sclk edge so sdin moves while sclk is high
    always_ff @(posedge clk_ifc) begin
        if (start) begin
            shreg <= spi_frame;
        end else if (active && tick && !sclk) begin
            shreg <= shreg << 1;
        end
    end

endmodule

//--- logic/dac_update_seq.sv
//////////////////////////////////////////////////////////////////////
// DAC update sequencer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "dac_ctrl_config.svh"

module dac_update_seq (
    input  var logic                    clk_ifc,
    input  var logic                    set_default_on_reset,
    input  var logic                    spi_ack,
    output var logic                    spi_req,
    output var dac_spi_pkg::dac_frame_t spi_frame,
    output var logic                    dac_data_in_updated_stb,
    dac_reg_if.seq_side                 dac
);
    import dac_spi_pkg::*;

    seq_state_e state;
    logic       ack_q;
    logic       ack_rise;
    logic       pending;       // update seen during a transfer
    logic       launch_next;
    dac_frame_t pend_frame;    // latest value while pending

    assign ack_rise    = spi_ack & ~ack_q;
    assign dac.busy    = (state != IDLE);

    // handshake back to zero, and something left to send
    assign launch_next = (state == SEND) & ~spi_req & ~spi_ack & (pending | dac.update);

    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            state                   <= START_AFTER_RESET;
            spi_req                 <= 1'b0;
            pending                 <= 1'b0;
            ack_q                   <= 1'b0;
            dac_data_in_updated_stb <= 1'b0;
            dac.init_done           <= 1'b0;
        end else begin
            ack_q                   <= spi_ack;
            dac_data_in_updated_stb <= ack_rise;
            if (ack_rise) begin
                dac.init_done <= 1'b1;   // first finished frame
            end

            case (state)
                START_AFTER_RESET: begin
                    spi_req <= 1'b1;
                    state   <= SEND;
                    if (dac.update) begin
                        pending <= 1'b1;
                    end
                end
                IDLE: begin
                    if (dac.update) begin
                        spi_req <= 1'b1;
                        state   <= SEND;
                    end
                end
                SEND: begin
                    if (spi_req && spi_ack) begin
                        spi_req <= 1'b0;
                    end else if (launch_next) begin
                        spi_req <= 1'b1;
                        pending <= 1'b0;
                    end else if (!spi_req && !spi_ack) begin
                        state <= IDLE;
                    end
                    if (dac.update && !launch_next) begin
                        pending <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // frame payload, held while spi_req is up
    always_ff @(posedge clk_ifc) begin
        if (dac.update) begin
            pend_frame <= dac.frame;
        end
        if (state == START_AFTER_RESET) begin
            spi_frame <= `DAC_DEFAULT;
        end else if (state == IDLE && dac.update) begin
            spi_frame <= dac.frame;
        end else if (launch_next) begin
            spi_frame <= dac.update ? dac.frame : pend_frame;  // newest wins
        end
    end

endmodule

//--- logic/avmm_reg_slave.sv
//////////////////////////////////////////////////////////////////////
// Avalon-MM register slave
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "dac_ctrl_config.svh"

module avmm_reg_slave (
    input  var logic                         clk_ifc,
    input  var logic                         set_default_on_reset,
    input  var dac_regs_pkg::bus_addr_t      avmm_address,
    input  var logic                         avmm_read,
    input  var logic                         avmm_write,
    input  var dac_regs_pkg::reg_word_t      avmm_writedata,
    input  var logic [`DAC_DATA_WIDTH/8-1:0] avmm_byteenable,
    output var logic                         avmm_waitrequest,
    output var dac_regs_pkg::reg_word_t      avmm_readdata,
    output var logic                         avmm_readdatavalid,
    output var logic                         avmm_writeresponsevalid,
    output var dac_regs_pkg::avmm_resp_e     avmm_response,
    input  var logic                         en_avmm_ctrl,
    input  var dac_spi_pkg::dac_code_t       dac_data_in,
    input  var logic                         dac_data_in_valid_stb,
    dac_reg_if.reg_side                      dac
);
    import dac_regs_pkg::*;
    import dac_spi_pkg::*;

    word_addr_t word_addr;
    logic       undefined;
    logic       rd_acc;
    logic       wr_acc;
    logic       dac_wr;        // bus write into DAC_REG
    logic       stream_wr;     // stream code into bits 13:6
    dac_frame_t dac_reg;
    reg_word_t  rd_word;

    // byte lanes only cover the low 16 bits
    function automatic dac_frame_t mask_lanes(
        input dac_frame_t                   cur,
        input reg_word_t                    wdata,
        input logic [`DAC_DATA_WIDTH/8-1:0] be
    );
        dac_frame_t res;
        res = cur;
        for (int i = 0; i < `DAC_FRAME_BITS/8; i++) begin
            if (be[i]) begin
                res[i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
        return res;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////

    assign word_addr = avmm_address[`DAC_ADDR_WIDTH-1:2];
    assign undefined = (word_addr >= TOTAL_REGS);

    // nothing is taken while waitrequest is still up
    assign rd_acc    = avmm_read & ~avmm_waitrequest;
    assign wr_acc    = avmm_write & ~avmm_waitrequest;

    assign dac_wr    = wr_acc & en_avmm_ctrl & (word_addr == DAC_REG);
    assign stream_wr = dac_data_in_valid_stb & ~en_avmm_ctrl;

    assign dac.frame = dac_reg;

    always_comb begin
        case (word_addr)
            VERSION_ID:   rd_word = {`DAC_MODULE_VERSION, `DAC_MODULE_ID};
            NUM_REGS:     rd_word = reg_word_t'(TOTAL_REGS);
            DEVICE_STATE: rd_word = reg_word_t'({dac.busy, dac.init_done});
            DAC_REG:      rd_word = reg_word_t'(dac_reg);
            EN_AVMM_CTRL: rd_word = reg_word_t'(en_avmm_ctrl);
            default:      rd_word = '0;    // undefined reads as zero
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // control and register storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_ifc) begin
        if (set_default_on_reset) begin
            avmm_waitrequest        <= 1'b1;
            avmm_readdatavalid      <= 1'b0;
            avmm_writeresponsevalid <= 1'b0;
            dac.update              <= 1'b0;
            dac_reg                 <= `DAC_DEFAULT;
        end else begin
            avmm_waitrequest        <= 1'b0;
            avmm_readdatavalid      <= rd_acc;
            avmm_writeresponsevalid <= wr_acc;
            dac.update              <= dac_wr | stream_wr;   // lines up with the response

            if (dac_wr) begin
                dac_reg <= mask_lanes(dac_reg, avmm_writedata, avmm_byteenable);
            end else if (stream_wr) begin
                dac_reg[`DAC_CODE_LSB +: `DAC_CODE_BITS] <= dac_data_in;
            end
        end
    end

    // read data and response
    always_ff @(posedge clk_ifc) begin
        if (rd_acc) begin
            avmm_readdata <= rd_word;
            avmm_response <= undefined ? SLAVE_ERROR : OKAY;
        end else if (wr_acc) begin
            avmm_response <= undefined ? SLAVE_ERROR : OKAY;  // read-only silently OKAY
        end
    end

endmodule

//--- logic/dac_reg_if.sv
//////////////////////////////////////////////////////////////////////
// Register slave to sequencer link
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface dac_reg_if;
    import dac_spi_pkg::*;

    logic       update;     // one-cycle pulse
    dac_frame_t frame;      // valid with update
    logic       busy;
    logic       init_done;

    modport reg_side (
        output update,
        output frame,
        input  busy,
        input  init_done
    );

    modport seq_side (
        input  update,
        input  frame,
        output busy,
        output init_done
    );

endinterface

//--- logic/dac_spi_pkg.sv
//////////////////////////////////////////////////////////////////////
// AD5601 frame and sequencer types
//////////////////////////////////////////////////////////////////////

`include "dac_ctrl_config.svh"

package dac_spi_pkg;

    typedef logic [`DAC_FRAME_BITS-1:0] dac_frame_t;
    typedef logic [`DAC_CODE_BITS-1:0]  dac_code_t;

    // frame bits 15:14
    typedef enum logic [1:0] {
        PM_NORMAL   = 2'b00,
        PM_PD_1K    = 2'b01,   // 1k to ground
        PM_PD_100K  = 2'b10,   // 100k to ground
        PM_PD_HIZ   = 2'b11    // three-state
    } power_mode_e;

    typedef enum logic [1:0] {
        IDLE,
        START_AFTER_RESET,
        SEND
    } seq_state_e;

endpackage

//--- logic/dac_regs_pkg.sv
//////////////////////////////////////////////////////////////////////
// DAC controller register map types
//////////////////////////////////////////////////////////////////////

`include "dac_ctrl_config.svh"

package dac_regs_pkg;

    // bus word and the register width
    typedef logic [`DAC_DATA_WIDTH-1:0] reg_word_t;

    typedef logic [`DAC_ADDR_WIDTH-1:0] bus_addr_t;   // byte address
    typedef logic [`DAC_ADDR_WIDTH-3:0] word_addr_t;  // 32-bit word index

    //////////////////////////////////////////////////////////////////////
    // register map
    //////////////////////////////////////////////////////////////////////

    typedef enum word_addr_t {
        VERSION_ID   = 0,
        NUM_REGS     = 1,
        DEVICE_STATE = 2,
        DAC_REG      = 3,
        EN_AVMM_CTRL = 4,
        TOTAL_REGS   = 5   // first undefined index
    } reg_addr_e;

    // Avalon-MM response codes
    typedef enum logic [1:0] {
        OKAY        = 2'd0,
        SLAVE_ERROR = 2'd2
    } avmm_resp_e;

endpackage

//--- logic/dac_ctrl_config.svh
//////////////////////////////////////////////////////////////////////
// AD5601 DAC controller configuration
//////////////////////////////////////////////////////////////////////

`ifndef DAC_CTRL_CONFIG_SVH
`define DAC_CTRL_CONFIG_SVH

// bus geometry
`define DAC_ADDR_WIDTH      8       // byte address
`define DAC_DATA_WIDTH      32

// AD5601 frame layout
`define DAC_FRAME_BITS      16
`define DAC_CODE_BITS       8
`define DAC_CODE_LSB        6       // code sits in frame bits 13:6

// identification
`define DAC_MODULE_ID       16'hda56
`define DAC_MODULE_VERSION  16'h0001

// normal power mode, mid-scale code
`define DAC_DEFAULT         16'h2000

// clocks per sclk half period
`define DAC_SCLK_DIV        2

`endif
